// File: source/mem_subsys_params.svh
`ifndef MEM_SUBSYS_PARAMS_SVH
`define MEM_SUBSYS_PARAMS_SVH

// Bus widths
`define ADDR_WIDTH        32
`define WORD_WIDTH        32
`define DATA_WIDTH_CACHE  128
`define LINE_BYTE_BITS    4    // Byte offset inside a line

// Instruction cache geometry
`define ICACHE_LINES      16
`define ICACHE_INDEX_BITS 4
`define ICACHE_WORD_BITS  2    // Word select inside a line

// Backing memory, indexed by address bits 11 to 4
`define MEM_LINES         256
`define MEM_INDEX_BITS    8
`define MEM_LATENCY       3

// Low data addresses land at an offset of 0x800
`define DATA_REMAP_HI     19
`define DATA_REMAP_LO     16
`define DATA_REMAP_OFFSET 32'h0000_0800

`endif

// File: source/bus_pkg.sv
`include "mem_subsys_params.svh"

package bus_pkg;

    // Byte address as seen by every requester
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // One cache line, the unit moved by the backing memory
    typedef logic [`DATA_WIDTH_CACHE-1:0] line_t;

    // One instruction word
    typedef logic [`WORD_WIDTH-1:0] word_t;

endpackage

// File: source/cache_pkg.sv
`include "mem_subsys_params.svh"

package cache_pkg;

    // Address bits above the line index
    typedef logic [`ADDR_WIDTH-`LINE_BYTE_BITS-`ICACHE_INDEX_BITS-1:0] tag_t;

    // Selects one of the cache lines
    typedef logic [`ICACHE_INDEX_BITS-1:0] index_t;

    // Selects the word inside a line
    typedef logic [`ICACHE_WORD_BITS-1:0] offset_t;

    // Controller states
    typedef enum logic [1:0] {
        LOOKUP,   // Idle, tag compare on request
        REFILL,   // Waiting for the line from memory
        RESPOND   // Refilled word is on the fetch port
    } icache_state_t;

endpackage

// File: source/icache.sv
`timescale 1ns/1ps
`include "mem_subsys_params.svh"

module icache (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  logic           fetch_req_i,
    input  bus_pkg::addr_t fetch_addr_i,
    output bus_pkg::word_t fetch_data_o,
    output logic           fetch_valid_o,
    output logic           mem_cs_o,
    output bus_pkg::addr_t mem_addr_o,
    input  bus_pkg::line_t mem_rdata_i,
    input  logic           mem_rvalid_i
);
    import bus_pkg::*;
    import cache_pkg::*;

    line_t line_q [`ICACHE_LINES];
    tag_t  tag_q  [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0] valid_q;

    icache_state_t state_q, state_d;

    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;

    // Request fields kept for the refill
    tag_t    miss_tag_q;
    index_t  miss_index_q;
    offset_t miss_offset_q;

    logic lookup_en;
    logic hit;
    logic refill_done;

    function automatic word_t word_sel(input line_t line, input offset_t off);
        word_sel = line[off*`WORD_WIDTH +: `WORD_WIDTH];
    endfunction

    assign {req_tag, req_index, req_offset} =
        fetch_addr_i[`ADDR_WIDTH-1:`LINE_BYTE_BITS-`ICACHE_WORD_BITS];

    // A new fetch may arrive in the RESPOND cycle as well
    assign lookup_en   = fetch_req_i && (state_q != REFILL);
    assign hit         = valid_q[req_index] && (tag_q[req_index] == req_tag);
    assign refill_done = (state_q == REFILL) && mem_rvalid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            LOOKUP, RESPOND: state_d = (lookup_en && !hit) ? REFILL : LOOKUP;
            REFILL:          if (mem_rvalid_i) state_d = RESPOND;
            default:         state_d = LOOKUP;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q       <= LOOKUP;
            valid_q       <= '0;
            fetch_valid_o <= 1'b0;
        end else begin
            state_q       <= state_d;
            fetch_valid_o <= (lookup_en && hit) || refill_done;
            if (refill_done) begin
                valid_q[miss_index_q] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (lookup_en) begin
            miss_tag_q    <= req_tag;
            miss_index_q  <= req_index;
            miss_offset_q <= req_offset;
        end
        if (lookup_en && hit) begin
            fetch_data_o <= word_sel(line_q[req_index], req_offset);
        end
        if (refill_done) begin
            line_q[miss_index_q] <= mem_rdata_i;
            tag_q[miss_index_q]  <= miss_tag_q;
            fetch_data_o         <= word_sel(mem_rdata_i, miss_offset_q);  // Bypass the array
        end
    end

    // Held from the miss through the rvalid cycle
    assign mem_cs_o   = (state_q == REFILL);
    assign mem_addr_o = {miss_tag_q, miss_index_q, {`LINE_BYTE_BITS{1'b0}}};

endmodule

// File: source/arbiter.sv
`timescale 1ns/1ps
`include "mem_subsys_params.svh"

module arbiter (
    input  logic           clk_i,
    input  logic           rst_ni,
    // Instruction cache side
    input  bus_pkg::addr_t i_addr_i,
    input  logic           i_cs_i,
    input  bus_pkg::line_t i_wdata_i,
    input  logic           i_we_i,
    output bus_pkg::line_t i_rdata_o,
    output logic           i_rvalid_o,
    // Data side
    input  bus_pkg::addr_t d_addr_i,
    input  logic           d_cs_i,
    input  bus_pkg::line_t d_wdata_i,
    input  logic           d_we_i,
    output bus_pkg::line_t d_rdata_o,
    output logic           d_rvalid_o,
    // Backing memory
    output bus_pkg::addr_t addr_o,
    output bus_pkg::line_t wdata_o,
    output logic           we_o,
    output logic           cs_o,
    input  bus_pkg::line_t rdata_i,
    input  logic           rvalid_i
);
    import bus_pkg::*;

    typedef enum logic [1:0] {IDLE, I_CACHE, MEM} arb_state_t;  // Owner of the read in flight

    arb_state_t state_q, state_d;

    logic  i_cs_gnt;
    logic  d_cs_gnt;
    logic  d_remap;
    addr_t d_addr_mapped;

    // Chip select is only raised to start a request
    always_comb begin
        case (state_q)
            I_CACHE: begin
                i_cs_gnt = 1'b0;
                d_cs_gnt = ~i_cs_i & d_cs_i;
            end
            MEM: begin
                i_cs_gnt = i_cs_i & ~d_cs_i;  // Waiting fetch starts once the data read is done
                d_cs_gnt = d_we_i;
            end
            default: begin
                i_cs_gnt = i_cs_i;
                d_cs_gnt = d_cs_i;
            end
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_cs_i)                  state_d = I_CACHE;
                else if (d_cs_i && !d_we_i)  state_d = MEM;
            end
            I_CACHE: begin
                if (!i_cs_i && (!d_cs_i || d_we_i)) state_d = IDLE;
                else if (!i_cs_i && d_cs_i)         state_d = MEM;
            end
            MEM: begin
                if (!i_cs_i && (!d_cs_i || d_we_i)) state_d = IDLE;
                else if (i_cs_i && (!d_cs_i || d_we_i)) state_d = I_CACHE;
            end
            default: state_d = IDLE;
        endcase
    end

    // Response steering
    always_comb begin
        i_rdata_o  = '0;
        i_rvalid_o = 1'b0;
        d_rdata_o  = '0;
        d_rvalid_o = 1'b0;
        if (state_q == I_CACHE) begin
            i_rdata_o  = rdata_i;
            i_rvalid_o = rvalid_i;
        end else if (state_q == MEM) begin
            d_rdata_o  = rdata_i;
            d_rvalid_o = rvalid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign d_remap       = (d_addr_i[`DATA_REMAP_HI:`DATA_REMAP_LO] == '0);
    assign d_addr_mapped = d_remap ?
        {d_addr_i[`ADDR_WIDTH-1:`LINE_BYTE_BITS], {`LINE_BYTE_BITS{1'b0}}} + `DATA_REMAP_OFFSET :
        d_addr_i;

    assign cs_o    = i_cs_gnt | d_cs_gnt;
    assign addr_o  = i_cs_i ? i_addr_i : d_addr_mapped;
    assign wdata_o = i_cs_i ? i_wdata_i : d_wdata_i;
    assign we_o    = i_cs_i ? i_we_i : (d_cs_i & d_we_i);

endmodule

// File: source/line_memory.sv
`timescale 1ns/1ps
`include "mem_subsys_params.svh"

module line_memory (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  logic           cs_i,
    input  logic           we_i,
    input  bus_pkg::addr_t addr_i,
    input  bus_pkg::line_t wdata_i,
    output bus_pkg::line_t rdata_o,
    output logic           rvalid_o
);
    import bus_pkg::*;

    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    line_t mem_q [`MEM_LINES];

    logic [`MEM_INDEX_BITS-1:0] index;
    logic [`MEM_INDEX_BITS-1:0] rd_index_q;
    logic [CNT_W-1:0]           cnt_q;
    logic                       busy;
    logic                       accept;

    initial begin
        for (int i = 0; i < `MEM_LINES; i++) begin
            mem_q[i] = '0;
        end
    end

    assign index  = addr_i[`LINE_BYTE_BITS +: `MEM_INDEX_BITS];
    assign busy   = (cnt_q != '0);  // Still set in the rvalid cycle
    assign accept = cs_i && !busy;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else if (accept && !we_i) begin
            cnt_q <= CNT_W'(`MEM_LATENCY);
        end else if (busy) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && we_i) begin
            mem_q[index] <= wdata_i;
        end
        if (accept && !we_i) begin
            rd_index_q <= index;
        end
    end

    // Last count of the read
    assign rvalid_o = (cnt_q == CNT_W'(1));
    assign rdata_o  = mem_q[rd_index_q];

endmodule

// File: source/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic           clk_i,
    input  logic           rst_ni,
    // Instruction fetch
    input  logic           fetch_req_i,
    input  bus_pkg::addr_t fetch_addr_i,
    output bus_pkg::word_t fetch_data_o,
    output logic           fetch_valid_o,
    // Line-wide data port
    input  logic           d_cs_i,
    input  logic           d_we_i,
    input  bus_pkg::addr_t d_addr_i,
    input  bus_pkg::line_t d_wdata_i,
    output bus_pkg::line_t d_rdata_o,
    output logic           d_rvalid_o
);
    import bus_pkg::*;

    logic  i_cs;
    addr_t i_addr;
    line_t i_rdata;
    logic  i_rvalid;

    logic  mem_cs;
    logic  mem_we;
    addr_t mem_addr;
    line_t mem_wdata;
    line_t mem_rdata;
    logic  mem_rvalid;

    icache u_icache (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .fetch_req_i  (fetch_req_i),
        .fetch_addr_i (fetch_addr_i),
        .fetch_data_o (fetch_data_o),
        .fetch_valid_o(fetch_valid_o),
        .mem_cs_o     (i_cs),
        .mem_addr_o   (i_addr),
        .mem_rdata_i  (i_rdata),
        .mem_rvalid_i (i_rvalid)
    );

    // Instruction side is read-only
    arbiter u_arbiter (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .i_addr_i  (i_addr),
        .i_cs_i    (i_cs),
        .i_wdata_i ('0),
        .i_we_i    (1'b0),
        .i_rdata_o (i_rdata),
        .i_rvalid_o(i_rvalid),
        .d_addr_i  (d_addr_i),
        .d_cs_i    (d_cs_i),
        .d_wdata_i (d_wdata_i),
        .d_we_i    (d_we_i),
        .d_rdata_o (d_rdata_o),
        .d_rvalid_o(d_rvalid_o),
        .addr_o    (mem_addr),
        .wdata_o   (mem_wdata),
        .we_o      (mem_we),
        .cs_o      (mem_cs),
        .rdata_i   (mem_rdata),
        .rvalid_i  (mem_rvalid)
    );

    line_memory u_line_memory (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .cs_i    (mem_cs),
        .we_i    (mem_we),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata),
        .rvalid_o(mem_rvalid)
    );

endmodule

// File: dv/mem_subsys_tb.sv
`timescale 1ns/1ps
`include "mem_subsys_params.svh"

module mem_subsys_tb;
    import bus_pkg::*;
    import cache_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESP_TIMEOUT = 4*`MEM_LATENCY + 8;  // Cycles
    localparam int N_REMAP      = 8;
    localparam int N_RAW        = 8;
    localparam int N_LINES      = 4;
    localparam int N_WORDS      = 4;  // Fetches per written line
    localparam int N_CONT       = 3;
    // Operations over the whole run, resets included
    localparam int N_OPS = 2*N_REMAP + 2*N_RAW + N_LINES*(1 + N_WORDS) + 6 + 2*N_CONT + 6;

    logic  clk_i = 1'b0;
    logic  rst_ni;
    logic  fetch_req;
    addr_t fetch_addr;
    word_t fetch_data;
    logic  fetch_valid;
    logic  d_cs;
    logic  d_we;
    addr_t d_addr;
    line_t d_wdata;
    line_t d_rdata;
    logic  d_rvalid;

    line_t       model_mem [`MEM_LINES];
    logic [31:0] lfsr_q = 32'he495_ad18;
    addr_t       first_fetch_addr;  // Cached by the eviction test, reused after reset
    int          errors = 0;
    int          checks = 0;

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    mem_subsys_top UUT (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .fetch_req_i  (fetch_req),
        .fetch_addr_i (fetch_addr),
        .fetch_data_o (fetch_data),
        .fetch_valid_o(fetch_valid),
        .d_cs_i       (d_cs),
        .d_we_i       (d_we),
        .d_addr_i     (d_addr),
        .d_wdata_i    (d_wdata),
        .d_rdata_o    (d_rdata),
        .d_rvalid_o   (d_rvalid)
    );

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic line_t fresh_line();
        line_t l;
        for (int k = 0; k < 4; k++) begin
            l[k*32 +: 32] = lfsr_bits(32);
        end
        return l;
    endfunction

    // Backing line hit by a data access, low addresses move up by 0x800
    function automatic int data_index(input addr_t a);
        addr_t m;
        m = a;
        if (a[19:16] == 4'h0) begin
            m = {a[31:4], 4'h0} + `DATA_REMAP_OFFSET;
        end
        return int'(m[11:4]);
    endfunction

    function automatic word_t word_of(input line_t l, input offset_t off);
        return l[off*`WORD_WIDTH +: `WORD_WIDTH];
    endfunction

    task automatic check_line(input string name, input line_t got, input line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic run_reset();
        rst_ni = 1'b0;
        repeat (5) begin
            @(negedge clk_i);
            compare_flag("fetch_valid", fetch_valid, 1'b0);
            compare_flag("d_rvalid", d_rvalid, 1'b0);
        end
        rst_ni = 1'b1;
        repeat (2) begin
            @(negedge clk_i);
            compare_flag("fetch_valid", fetch_valid, 1'b0);
            compare_flag("d_rvalid", d_rvalid, 1'b0);
        end
    endtask

    // Single-cycle write, also applied to the model
    task automatic data_write(input addr_t a, input line_t l);
        @(negedge clk_i);
        d_cs    = 1'b1;
        d_we    = 1'b1;
        d_addr  = a;
        d_wdata = l;
        @(negedge clk_i);
        d_cs = 1'b0;
        d_we = 1'b0;
        model_mem[data_index(a)] = l;
    endtask

    task automatic data_read(input addr_t a, output line_t data, output bit ok);
        int cyc;
        @(negedge clk_i);
        d_cs   = 1'b1;
        d_we   = 1'b0;
        d_addr = a;
        cyc    = 0;
        ok     = 1'b0;
        while (!ok && cyc < RESP_TIMEOUT) begin
            @(negedge clk_i);
            cyc++;
            if (d_rvalid) begin
                ok   = 1'b1;
                data = d_rdata;
            end
        end
        d_cs = 1'b0;
        if (!ok) note_failure($sformatf("no d_rvalid for read of %h within %0d cycles",
                                        a, RESP_TIMEOUT));
    endtask

    // Returns the cycles to fetch_valid, zero when none came
    task automatic fetch_and_compare(input addr_t a, output int cyc);
        bit ok;
        @(negedge clk_i);
        fetch_req  = 1'b1;
        fetch_addr = a;
        cyc        = 0;
        ok         = 1'b0;
        while (!ok && cyc < RESP_TIMEOUT) begin
            @(negedge clk_i);
            fetch_req = 1'b0;
            cyc++;
            if (fetch_valid) begin
                ok = 1'b1;
                check_word("fetch_data", fetch_data, word_of(model_mem[a[11:4]], a[3:2]));
            end
        end
        if (!ok) begin
            cyc = 0;
            note_failure($sformatf("no fetch_valid for fetch of %h within %0d cycles",
                                   a, RESP_TIMEOUT));
        end
    endtask

    task automatic remapped_round_trip();
        addr_t addrs [N_REMAP];
        line_t got;
        bit    ok;
        for (int k = 0; k < N_REMAP; k++) begin
            addrs[k]        = lfsr_bits(32);
            addrs[k][19:16] = 4'h0;
            data_write(addrs[k], fresh_line());
        end
        for (int k = 0; k < N_REMAP; k++) begin
            data_read(addrs[k], got, ok);
            if (ok) check_line("d_rdata", got, model_mem[data_index(addrs[k])]);
        end
    endtask

    task automatic raw_round_trip();
        logic [7:0] raw_idx [N_RAW];
        addr_t      a;
        line_t      got;
        bit         ok;
        for (int k = 0; k < N_RAW; k++) begin
            a = lfsr_bits(32);
            if (a[19:16] == 4'h0) a[19:16] = 4'h1;
            raw_idx[k] = a[11:4];
            data_write(a, fresh_line());
        end
        // Alias whose remapped line is the raw one
        for (int k = 0; k < N_RAW; k++) begin
            a        = lfsr_bits(32);
            a[19:16] = 4'h0;
            a[11:4]  = raw_idx[k] ^ 8'h80;
            data_read(a, got, ok);
            if (ok) check_line("d_rdata", got, model_mem[raw_idx[k]]);
        end
    endtask

    task automatic fetch_after_write();
        addr_t   a;
        offset_t off;
        int      cyc;
        for (int n = 0; n < N_LINES; n++) begin
            a = lfsr_bits(32);
            if (a[19:16] == 4'h0) a[19:16] = 4'h2;
            data_write(a, fresh_line());
            for (int j = 0; j < N_WORDS; j++) begin
                off = offset_t'(lfsr_bits(2));
                fetch_and_compare({12'h300, 8'(n), a[11:4], off, 2'b00}, cyc);  // Fresh tag
            end
        end
    endtask

    task automatic hit_and_eviction();
        logic [7:0] idx;
        addr_t      other;
        int         cyc;
        idx = 8'(lfsr_bits(8));
        data_write({12'h000, 4'h1, 4'h0, idx, 4'h0}, fresh_line());
        data_write({12'h000, 4'h1, 4'h0, idx ^ 8'h10, 4'h0}, fresh_line());
        // Same cache index, different tag and backing line
        first_fetch_addr = {12'h400, 8'h01, idx, 2'(lfsr_bits(2)), 2'b00};
        other            = {12'h400, 8'h02, idx ^ 8'h10, 2'(lfsr_bits(2)), 2'b00};
        fetch_and_compare(first_fetch_addr, cyc);
        fetch_and_compare(first_fetch_addr, cyc);
        if (cyc > 1) note_failure($sformatf("cached fetch took %0d cycles instead of 1", cyc));
        fetch_and_compare(other, cyc);
        fetch_and_compare(first_fetch_addr, cyc);
    endtask

    task automatic contention();
        logic [7:0] idx;
        addr_t      fa;
        addr_t      da;
        int         cyc;
        int         f_cyc;
        int         d_cyc;
        for (int r = 0; r < N_CONT; r++) begin
            idx = 8'(lfsr_bits(8));
            data_write({12'h000, 4'h3, 4'h0, idx, 4'h0}, fresh_line());
            fa    = {12'h500, 8'(r), idx, 2'(lfsr_bits(2)), 2'b00};
            da    = lfsr_bits(32);
            f_cyc = 0;
            d_cyc = 0;
            cyc   = 0;
            @(negedge clk_i);
            fetch_req  = 1'b1;
            fetch_addr = fa;
            while ((f_cyc == 0 || d_cyc == 0) && cyc < 2*RESP_TIMEOUT) begin
                @(negedge clk_i);
                cyc++;
                if (fetch_valid && f_cyc == 0) begin
                    f_cyc = cyc;
                    check_word("fetch_data", fetch_data, word_of(model_mem[fa[11:4]], fa[3:2]));
                end
                if (d_rvalid && d_cyc == 0) begin
                    d_cyc = cyc;
                    d_cs  = 1'b0;
                    check_line("d_rdata", d_rdata, model_mem[data_index(da)]);
                end
                if (cyc == 1) begin  // Data chip select rises with the refill request
                    fetch_req = 1'b0;
                    d_cs      = 1'b1;
                    d_we      = 1'b0;
                    d_addr    = da;
                end
            end
            d_cs = 1'b0;
            if (f_cyc == 0) note_failure("fetch_valid never came during contention");
            if (d_cyc == 0) note_failure("d_rvalid never came during contention");
            if (f_cyc != 0 && d_cyc != 0 && f_cyc >= d_cyc)
                note_failure("data read returned before the competing fetch");
        end
    endtask

    task automatic reset_state();
        int cyc;
        fetch_and_compare(first_fetch_addr, cyc);  // Line is cached before reset
        // Miss still in flight when reset comes
        @(negedge clk_i);
        fetch_req  = 1'b1;
        fetch_addr = {12'h600, first_fetch_addr[19:0] ^ 20'h0_0010};
        @(negedge clk_i);
        fetch_req = 1'b0;
        run_reset();
        fetch_and_compare(first_fetch_addr, cyc);
        if (cyc == 1) note_failure("first fetch after reset hit in the cache");
    endtask

    task automatic finish_test(input string name, input int err_before);
        $display("%-26s %s, %0d errors", name,
                 (errors == err_before) ? "pass" : "FAIL", errors - err_before);
    endtask

    initial begin
        int e0;
        rst_ni     = 1'b0;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        d_cs       = 1'b0;
        d_we       = 1'b0;
        d_addr     = '0;
        d_wdata    = '0;
        for (int i = 0; i < `MEM_LINES; i++) model_mem[i] = '0;
        run_reset();

        e0 = errors;
        remapped_round_trip();
        finish_test("remapped data round trip", e0);
        e0 = errors;
        raw_round_trip();
        finish_test("unmapped data round trip", e0);
        e0 = errors;
        fetch_after_write();
        finish_test("fetch after data write", e0);
        e0 = errors;
        hit_and_eviction();
        finish_test("hit and eviction", e0);
        e0 = errors;
        contention();
        finish_test("contention", e0);
        e0 = errors;
        reset_state();
        finish_test("reset state", e0);

        $display("checks %0d, failures %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(N_OPS * RESP_TIMEOUT * CLK_PERIOD);
        $display("watchdog expired at %0t, the run did not complete", $time);
        $display("Errors found");
        $finish;
    end

endmodule

// File: flist.f
+incdir+source
source/bus_pkg.sv
source/cache_pkg.sv
source/icache.sv
source/arbiter.sv
source/line_memory.sv
source/mem_subsys_top.sv
dv/mem_subsys_tb.sv
